//--- sources.f
+incdir+.
game_pkg.sv
video_pkg.sv
stacker_ifs.sv
button_conditioner.sv
drop_timer.sv
game_engine.sv
scan_timing.sv
pixel_renderer.sv
stacker_top.sv
tb_stacker.sv

//--- tb_stacker.sv
`include "stacker_cfg.svh"

module tb_stacker;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int H_TOT = `H_ACTIVE + `H_FP + `H_SYNC + `H_BP;
  localparam int V_TOT = `V_ACTIVE + `V_FP + `V_SYNC + `V_BP;
  localparam int HS_X  = `H_ACTIVE + `H_FP;
  localparam int VS_Y  = `V_ACTIVE + `V_FP;
  localparam int LAST  = `BOARD_ROWS - 1;

  logic       hz100, arst_n, btn_left, btn_right, btn_drop, btn_start;
  logic       red, green, blue, hsync, vsync, game_over;
  logic [7:0] score;

  int    errors = 0;
  int    seed = 32'h31c490b4;
  string test_name = "reset";

  // Reference game state and the copy the renderer is showing this cycle
  bit m_b[`BOARD_ROWS][`BOARD_COLS];
  bit s_b[`BOARD_ROWS][`BOARD_COLS];
  int m_row, m_col, m_score, s_row, s_col, s_score;
  bit m_over, s_over, pend_l, pend_r;
  int pieces = 0;

  // Button pins seen at the last four clock edges
  bit [3:0] pin_d1, pin_d2, pin_d3, pin_d4;
  bit [2:0] pulse;  // Start, right, left
  int       tick_gap = 0;
  int       tick_exp = 0;
  int       iv_now = 0;
  int       iv_last = 0;
  bit       gap_clean = 1'b0;

  // Rebuilt pixel position starts one pixel before the origin
  int   hx = H_TOT - 1;
  int   vy = V_TOT - 1;
  int   frames = 0;
  int   hs_low = 0;
  int   vs_low = 0;
  logic run_q = 1'b0;
  logic hs_prev = 1'b1;
  logic vs_prev = 1'b1;

  stacker_top dut_i (.*);

  always #4 hz100 = ~hz100;

  task automatic report(string what, int exp, int act);
    errors++;
    $display("** Error %s: %s expected %0d actual %0d", test_name, what, exp, act);
  endtask

  function automatic logic [2:0] exp_color(int x, int y);
    int bx, by;
    bit in_b, ring, bar;
    bx   = x - `BOARD_X0;
    by   = y - `BOARD_Y0;
    in_b = bx >= 0 && bx < `BOARD_COLS * `CELL_PX && by >= 0 && by < `BOARD_ROWS * `CELL_PX;
    ring = !in_b && bx >= -`CELL_PX && bx < (`BOARD_COLS + 1) * `CELL_PX &&
           by >= -`CELL_PX && by < (`BOARD_ROWS + 1) * `CELL_PX;
    bar  = by >= -2 * `CELL_PX && by < -`CELL_PX && bx >= 0 && bx < 2 * s_score;
    if (x >= `H_ACTIVE || y >= `V_ACTIVE) return 3'b000;
    if (bar) return 3'b010;   // Green bar wins over everything
    if (ring) return 3'b111;
    if (!in_b) return 3'b000;
    if (by / `CELL_PX == s_row && bx / `CELL_PX == s_col) return 3'b110;
    if (s_b[by / `CELL_PX][bx / `CELL_PX]) return s_over ? 3'b100 : 3'b011;
    return 3'b000;
  endfunction

  // Drop period in cycles for a score and the drop button level
  function automatic int drop_interval(int sc, bit fast);
    int iv;
    iv = `TICK_BASE >> ((sc < 3) ? sc : 3);
    return fast ? iv / 4 : iv;
  endfunction

  task automatic reset_model();
    foreach (m_b[r, c]) m_b[r][c] = 1'b0;
    m_row   = 0;
    m_col   = `SPAWN_COL;
    m_score = 0;
    m_over  = 1'b0;
    pend_l  = 1'b0;
    pend_r  = 1'b0;
  endtask

  task automatic step_move(bit l, bit r);
    if (l && !r && m_col > 0 && !m_b[m_row][m_col-1]) begin
      m_col--;
    end else if (r && !l && m_col < `BOARD_COLS - 1 && !m_b[m_row][m_col+1]) begin
      m_col++;
    end
  endtask

  // Fall one row, or lock, clear full rows and respawn
  task automatic step_drop();
    bit nb[`BOARD_ROWS][`BOARD_COLS];
    bit full;
    int dst;
    if (m_row < LAST && !m_b[m_row+1][m_col]) begin
      m_row++;
      return;
    end
    foreach (nb[r, c]) nb[r][c] = 1'b0;
    m_b[m_row][m_col] = 1'b1;
    dst = LAST;
    for (int r = LAST; r >= 0; r--) begin
      full = 1'b1;
      for (int c = 0; c < `BOARD_COLS; c++) full &= m_b[r][c];
      if (full) begin
        m_score = (m_score < 255) ? m_score + 1 : 255;
      end else begin
        nb[dst] = m_b[r];
        dst--;
      end
    end
    m_b    = nb;
    m_row  = 0;
    m_col  = `SPAWN_COL;
    m_over = m_b[0][`SPAWN_COL];
    pieces++;
  endtask

  // Model steps on its own presses, three edges late, and on the drop ticks
  always @(posedge hz100) begin
    run_q <= arst_n;
    s_b = m_b;
    s_row = m_row;
    s_col = m_col;
    s_score = m_score;
    s_over = m_over;
    pulse = {pin_d3[3], pin_d3[1:0]} & ~{pin_d4[3], pin_d4[1:0]};
    iv_now = drop_interval(s_score, pin_d3[2]);
    pin_d4 = pin_d3;
    pin_d3 = pin_d2;
    pin_d2 = pin_d1;
    pin_d1 = {btn_start, btn_drop, btn_right, btn_left};
    if (!arst_n || pulse[2]) begin
      reset_model();
      gap_clean = 1'b0;
    end else if (!m_over) begin
      tick_gap++;
      if (dut_i.tick) begin
        if (gap_clean) begin
          assert (tick_gap == tick_exp) else report("drop interval", tick_exp, tick_gap);
        end
        tick_gap  = 0;
        tick_exp  = iv_last;
        gap_clean = (iv_now == iv_last);
        step_drop();
        pend_l = pulse[0];   // Move waits behind the drop
        pend_r = pulse[1];
      end else begin
        if (iv_now != tick_exp) gap_clean = 1'b0;  // Period changed mid-count
        step_move(pulse[0] | pend_l, pulse[1] | pend_r);
        pend_l = 1'b0;
        pend_r = 1'b0;
      end
    end
    iv_last = iv_now;
  end

  always @(negedge hz100) begin
    if (run_q) begin
      if (hx == H_TOT - 1) begin
        hx = 0;
        vy = (vy == V_TOT - 1) ? 0 : vy + 1;
        if (vy == 0) frames++;
      end else begin
        hx++;
      end
      if (hs_prev && !hsync) assert (hx == HS_X) else report("x at hsync fall", HS_X, hx);
      if (vs_prev && !vsync) assert (vy == VS_Y) else report("y at vsync fall", VS_Y, vy);
      if (!hs_prev && hsync) assert (hs_low == `H_SYNC) else report("hsync low", `H_SYNC, hs_low);
      if (!vs_prev && vsync) begin
        assert (vs_low == `V_SYNC * H_TOT) else report("vsync low", `V_SYNC * H_TOT, vs_low);
      end
      hs_low = hsync ? 0 : hs_low + 1;
      vs_low = vsync ? 0 : vs_low + 1;
      assert ({red, green, blue} == exp_color(hx, vy))
        else report($sformatf("color at %0d,%0d", hx, vy), exp_color(hx, vy), {red, green, blue});
      assert (score == m_score) else report("score", m_score, score);
      assert (game_over == m_over) else report("game_over", m_over, game_over);
    end
    hs_prev = hsync;
    vs_prev = vsync;
  end

  sync_window: assert property (@(posedge hz100) disable iff (!run_q)
    (hsync == !(hx >= HS_X && hx < HS_X + `H_SYNC)) &&
    (vsync == !(vy >= VS_Y && vy < VS_Y + `V_SYNC)))
    else begin
      errors++;
      $display("** Error %s: sync level out of its window at %0d,%0d", test_name, hx, vy);
    end

  task automatic press(int which);
    int hold;
    hold = 2 + ($random(seed) & 3);
    @(negedge hz100);
    if (which == 0) btn_left = 1'b1;
    else if (which == 1) btn_right = 1'b1;
    else btn_start = 1'b1;
    repeat (hold) @(negedge hz100);
    btn_left  = 1'b0;
    btn_right = 1'b0;
    btn_start = 1'b0;
    repeat (6) @(negedge hz100);
  endtask

  task automatic wait_lock();
    int target;
    int t;
    target = pieces + 1;
    for (t = 0; t < 200000 && pieces < target && !m_over; t++) @(negedge hz100);
    if (pieces < target && !m_over) begin
      errors++;
      $display("Timeout in %s: no piece locked", test_name);
    end
  endtask

  task automatic wait_frames(int n);
    int target;
    int t;
    target = frames + n;
    for (t = 0; t < n * 500000 && frames < target; t++) @(negedge hz100);
    if (frames < target) begin
      errors++;
      $display("Timeout in %s: video frames stopped", test_name);
    end
  endtask

  initial begin
    hz100     = 1'b0;
    arst_n    = 1'b0;
    btn_left  = 1'b0;
    btn_right = 1'b0;
    btn_drop  = 1'b0;
    btn_start = 1'b0;
    repeat (10) @(negedge hz100);
    assert (score == 0) else report("score", 0, score);
    assert (game_over == 0) else report("game_over", 0, game_over);
    assert (hsync && vsync) else report("syncs", 3, {hsync, vsync});
    arst_n = 1'b1;
    wait_frames(2);   // Whole first frame

    test_name = "drop and move";
    wait_lock();
    repeat (6) press(0);  // Runs into the left wall
    wait_lock();

    test_name = "row clear";
    for (int c = 1; c < `BOARD_COLS; c++) begin
      if (!m_b[LAST][c] && !m_over) begin
        for (int k = 0; k < ((c > `SPAWN_COL) ? c - `SPAWN_COL : `SPAWN_COL - c); k++)
          press((c > `SPAWN_COL) ? 1 : 0);
        btn_drop = 1'b1;
        wait_lock();
        btn_drop = 1'b0;
      end
    end
    assert (score == 1) else report("score", 1, score);

    test_name = "game over";
    btn_drop = 1'b1;
    for (int p = 0; p < 25 && !m_over; p++) wait_lock();
    btn_drop = 1'b0;
    assert (game_over == 1) else report("game_over", 1, game_over);
    test_name = "red board and score bar";
    wait_frames(2);

    test_name = "start";
    press(2);
    assert (score == 0) else report("score", 0, score);
    assert (game_over == 0) else report("game_over", 0, game_over);
    wait_frames(2);

    $display("Run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- stacker_top.sv
module stacker_top import game_pkg::*; (
  input  logic   hz100,
  input  logic   arst_n,
  input  logic   btn_left,
  input  logic   btn_right,
  input  logic   btn_drop,
  input  logic   btn_start,
  output logic   red,
  output logic   green,
  output logic   blue,
  output logic   hsync,
  output logic   vsync,
  output score_t score,
  output logic   game_over
);

  btn_if   btn ();
  board_if brd ();
  scan_if  scan ();
  logic    tick;  // One cycle per drop step

  button_conditioner u_buttons (
    .hz100    (hz100),
    .arst_n   (arst_n),
    .btn_left (btn_left),
    .btn_right(btn_right),
    .btn_drop (btn_drop),
    .btn_start(btn_start),
    .btn      (btn.source)
  );

  drop_timer u_timer (.hz100(hz100), .arst_n(arst_n), .btn(btn.sink), .brd(brd.view),
                      .tick(tick));

  game_engine u_engine (.hz100(hz100), .arst_n(arst_n), .btn(btn.sink), .tick(tick),
                        .brd(brd.source));

  scan_timing u_scan (.hz100(hz100), .arst_n(arst_n), .scan(scan.source));

  pixel_renderer u_render (
    .hz100 (hz100),
    .arst_n(arst_n),
    .scan  (scan.sink),
    .brd   (brd.view),
    .red   (red),
    .green (green),
    .blue  (blue),
    .hsync (hsync),
    .vsync (vsync)
  );

  assign score     = brd.score;
  assign game_over = brd.game_over;

endmodule

//--- pixel_renderer.sv
`include "stacker_cfg.svh"

module pixel_renderer import game_pkg::*, video_pkg::*; (
  input  logic  hz100,
  input  logic  arst_n,
  scan_if.sink  scan,
  board_if.view brd,
  output logic  red,
  output logic  green,
  output logic  blue,
  output logic  hsync,
  output logic  vsync
);

  localparam int CELL_SH = $clog2(`CELL_PX);
  localparam int X0      = `BOARD_X0;
  localparam int Y0      = `BOARD_Y0;
  localparam int BW      = `BOARD_COLS * `CELL_PX;
  localparam int BH      = `BOARD_ROWS * `CELL_PX;
  localparam int CP      = `CELL_PX;

  coord_t bx, by;  // Offset from the board origin
  logic   in_board, in_ring, in_bar;
  row_t   cell_row;
  col_t   cell_col;
  color_t color_d, color_q;
  logic   hsync_q, vsync_q;

  always_comb begin
    bx       = scan.x - coord_t'(X0);
    by       = scan.y - coord_t'(Y0);
    cell_row = row_t'(by >> CELL_SH);
    cell_col = col_t'(bx >> CELL_SH);
    in_board = (scan.x >= coord_t'(X0)) && (scan.x < coord_t'(X0 + BW)) &&
               (scan.y >= coord_t'(Y0)) && (scan.y < coord_t'(Y0 + BH));
    in_ring  = (scan.x >= coord_t'(X0 - CP)) && (scan.x < coord_t'(X0 + BW + CP)) &&
               (scan.y >= coord_t'(Y0 - CP)) && (scan.y < coord_t'(Y0 + BH + CP)) &&
               !in_board;
    // One cell row above the ring, 2 px per cleared row
    in_bar   = (scan.y >= coord_t'(Y0 - 2 * CP)) && (scan.y < coord_t'(Y0 - CP)) &&
               (scan.x >= coord_t'(X0)) && (bx < coord_t'({brd.score, 1'b0}));

    if (!scan.active) begin
      color_d = C_BLACK;
    end else if (in_bar) begin
      color_d = C_GREEN;
    end else if (in_ring) begin
      color_d = C_WHITE;
    end else if (in_board && cell_row == brd.piece_row && cell_col == brd.piece_col) begin
      color_d = C_YELLOW;
    end else if (in_board && brd.board[cell_row][cell_col]) begin
      color_d = brd.game_over ? C_RED : C_CYAN;
    end else begin
      color_d = C_BLACK;
    end
  end

  // Syncs go through the same stage so they line up with the color
  always_ff @(posedge hz100 or negedge arst_n) begin
    if (!arst_n) begin
      color_q <= C_BLACK;
      hsync_q <= 1'b1;
      vsync_q <= 1'b1;
    end else begin
      color_q <= color_d;
      hsync_q <= scan.hsync;
      vsync_q <= scan.vsync;
    end
  end

  assign red   = color_q[2];
  assign green = color_q[1];
  assign blue  = color_q[0];
  assign hsync = hsync_q;
  assign vsync = vsync_q;

endmodule

//--- scan_timing.sv
`include "stacker_cfg.svh"

module scan_timing import video_pkg::*; (
  input  logic   hz100,
  input  logic   arst_n,
  scan_if.source scan
);

  localparam int H_TOTAL   = `H_ACTIVE + `H_FP + `H_SYNC + `H_BP;
  localparam int V_TOTAL   = `V_ACTIVE + `V_FP + `V_SYNC + `V_BP;
  localparam int HS_START  = `H_ACTIVE + `H_FP;
  localparam int VS_START  = `V_ACTIVE + `V_FP;

  coord_t h_q;
  coord_t v_q;

  always_ff @(posedge hz100 or negedge arst_n) begin
    if (!arst_n) begin
      h_q <= '0;
      v_q <= '0;
    end else if (h_q == coord_t'(H_TOTAL - 1)) begin
      h_q <= '0;
      // End of line, step the line counter
      if (v_q == coord_t'(V_TOTAL - 1)) begin
        v_q <= '0;
      end else begin
        v_q <= v_q + 1'b1;
      end
    end else begin
      h_q <= h_q + 1'b1;
    end
  end

  assign scan.x      = h_q;
  assign scan.y      = v_q;
  assign scan.active = (h_q < coord_t'(`H_ACTIVE)) && (v_q < coord_t'(`V_ACTIVE));
  assign scan.hsync  = !((h_q >= coord_t'(HS_START)) &&
                         (h_q < coord_t'(HS_START + `H_SYNC)));
  assign scan.vsync  = !((v_q >= coord_t'(VS_START)) &&
                         (v_q < coord_t'(VS_START + `V_SYNC)));

  x_in_line: assert property (@(posedge hz100) disable iff (!arst_n)
    h_q < coord_t'(H_TOTAL))
    else $error("horizontal count past the line total");

endmodule

//--- game_engine.sv
`include "stacker_cfg.svh"

module game_engine import game_pkg::*; (
  input  logic    hz100,
  input  logic    arst_n,
  btn_if.sink     btn,
  input  logic    tick,
  board_if.source brd
);

  localparam int LAST_ROW = `BOARD_ROWS - 1;
  localparam int LAST_COL = `BOARD_COLS - 1;

  board_t     board_q;
  row_t       row_q;
  col_t       col_q;
  score_t     score_q;
  logic       over_q;
  logic       pend_left_q, pend_right_q;  // Moves held behind a drop

  logic       go_left, go_right;
  logic       can_fall, can_left, can_right;
  board_t     locked;
  board_t     compact;
  logic [4:0] cleared;
  logic [8:0] score_sum;

  assign go_left  = btn.move_left | pend_left_q;
  assign go_right = btn.move_right | pend_right_q;

  // Bounds are tested before the cell so the index stays in range
  always_comb begin
    can_fall  = (row_q != row_t'(LAST_ROW)) && !board_q[row_q + 1'b1][col_q];
    can_left  = (col_q != '0) && !board_q[row_q][col_q - 1'b1];
    can_right = (col_q != col_t'(LAST_COL)) && !board_q[row_q][col_q + 1'b1];
  end

  // Lock the piece, then pack the rows that are not full toward the floor
  always_comb begin
    int dst;
    dst    = LAST_ROW;
    locked = board_q;
    locked[row_q][col_q] = 1'b1;
    compact = '0;
    cleared = '0;
    for (int r = LAST_ROW; r >= 0; r--) begin
      if (&locked[r]) begin
        cleared = cleared + 1'b1;
      end else begin
        compact[dst] = locked[r];
        dst = dst - 1;
      end
    end
    score_sum = {1'b0, score_q} + {4'b0, cleared};
  end

  always_ff @(posedge hz100 or negedge arst_n) begin
    if (!arst_n) begin
      board_q      <= '0;
      row_q        <= '0;
      col_q        <= col_t'(`SPAWN_COL);
      score_q      <= '0;
      over_q       <= 1'b0;
      pend_left_q  <= 1'b0;
      pend_right_q <= 1'b0;
    end else if (btn.start) begin
      board_q      <= '0;
      row_q        <= '0;
      col_q        <= col_t'(`SPAWN_COL);
      score_q      <= '0;
      over_q       <= 1'b0;
      pend_left_q  <= 1'b0;
      pend_right_q <= 1'b0;
    end else if (!over_q) begin
      if (tick) begin
        pend_left_q  <= btn.move_left;
        pend_right_q <= btn.move_right;
        if (can_fall) begin
          row_q <= row_q + 1'b1;
        end else begin
          board_q <= compact;
          score_q <= score_sum[8] ? SCORE_MAX : score_sum[7:0];
          row_q   <= '0;  // Respawn at the top
          col_q   <= col_t'(`SPAWN_COL);
          over_q  <= compact[0][`SPAWN_COL];
        end
      end else begin
        pend_left_q  <= 1'b0;
        pend_right_q <= 1'b0;
        if (go_left && !go_right && can_left) begin
          col_q <= col_q - 1'b1;
        end else if (go_right && !go_left && can_right) begin
          col_q <= col_q + 1'b1;
        end
      end
    end
  end

  assign brd.board     = board_q;
  assign brd.piece_row = row_q;
  assign brd.piece_col = col_q;
  assign brd.score     = score_q;
  assign brd.game_over = over_q;

  piece_in_board: assert property (@(posedge hz100) disable iff (!arst_n)
    (row_q <= row_t'(LAST_ROW)) && (col_q <= col_t'(LAST_COL)))
    else $error("piece outside the board");

  // Spawning onto a locked cell is the game over case
  piece_free: assert property (@(posedge hz100) disable iff (!arst_n || over_q)
    !board_q[row_q][col_q])
    else $error("piece overlaps a locked cell");

endmodule

//--- drop_timer.sv
`include "stacker_cfg.svh"

module drop_timer import game_pkg::*; (
  input  logic  hz100,
  input  logic  arst_n,
  btn_if.sink   btn,
  board_if.view brd,
  output logic  tick
);

  localparam int CNT_W = $clog2(`TICK_BASE) + 1;

  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] interval;
  logic [1:0]       shift;

  // Faster with every cleared row, up to 8x, then 4x more on the drop button
  always_comb begin
    shift    = (brd.score > score_t'(3)) ? 2'd3 : brd.score[1:0];
    interval = CNT_W'(`TICK_BASE) >> shift;
    if (btn.fast_drop) begin
      interval = interval >> 2;
    end
  end

  always_ff @(posedge hz100 or negedge arst_n) begin
    if (!arst_n) begin
      count_q <= CNT_W'(`TICK_BASE - 1);
      tick    <= 1'b0;
    end else begin
      tick <= 1'b0;
      if (btn.start || brd.game_over) begin
        count_q <= interval - 1'b1;  // Parked until the next game
      end else if (count_q == '0) begin
        count_q <= interval - 1'b1;
        tick    <= 1'b1;
      end else if (count_q >= interval) begin
        count_q <= interval - 1'b1;  // Interval just shrank
      end else begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  tick_single: assert property (@(posedge hz100) disable iff (!arst_n) tick |=> !tick)
    else $error("drop tick high for two cycles");

endmodule

//--- button_conditioner.sv
module button_conditioner (
  input  logic  hz100,
  input  logic  arst_n,
  input  logic  btn_left,
  input  logic  btn_right,
  input  logic  btn_drop,
  input  logic  btn_start,
  btn_if.source btn
);

  logic [3:0] raw;
  logic [3:0] sync1_q, sync2_q;  // Order is start, drop, right, left
  logic [2:0] edge_src;          // Start, right, left
  logic [2:0] prev_q;
  logic [2:0] pulse_q;
  logic       drop_q;

  assign raw      = {btn_start, btn_drop, btn_right, btn_left};
  assign edge_src = {sync2_q[3], sync2_q[1:0]};

  always_ff @(posedge hz100 or negedge arst_n) begin
    if (!arst_n) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
      pulse_q <= '0;
      drop_q  <= 1'b0;
    end else begin
      sync1_q <= raw;
      sync2_q <= sync1_q;
      prev_q  <= edge_src;
      pulse_q <= edge_src & ~prev_q;  // One cycle per press
      drop_q  <= sync2_q[2];          // Same latency as the pulses
    end
  end

  assign btn.move_left  = pulse_q[0];
  assign btn.move_right = pulse_q[1];
  assign btn.start      = pulse_q[2];
  assign btn.fast_drop  = drop_q;

endmodule

//--- stacker_ifs.sv
// Conditioned buttons
interface btn_if ();
  logic move_left;
  logic move_right;
  logic start;
  logic fast_drop;  // Level, not a pulse

  modport source (output move_left, move_right, start, fast_drop);
  modport sink   (input  move_left, move_right, start, fast_drop);
endinterface

// Game state as seen by the timer and the renderer
interface board_if import game_pkg::*; ();
  board_t board;
  row_t   piece_row;
  col_t   piece_col;
  score_t score;
  logic   game_over;

  modport source (output board, piece_row, piece_col, score, game_over);
  modport view   (input  board, piece_row, piece_col, score, game_over);
endinterface

// Raster position and syncs
interface scan_if import video_pkg::*; ();
  coord_t x;
  coord_t y;
  logic   active;
  logic   hsync;  // Active low
  logic   vsync;  // Active low

  modport source (output x, y, active, hsync, vsync);
  modport sink   (input  x, y, active, hsync, vsync);
endinterface

//--- video_pkg.sv
package video_pkg;

  // Bit 2 red, bit 1 green, bit 0 blue
  typedef logic [2:0] color_t;

  // Pixel position, wide enough for the 800x525 totals
  typedef logic [9:0] coord_t;

  localparam color_t C_BLACK  = 3'b000;  // Empty cell and blanking
  localparam color_t C_CYAN   = 3'b011;  // Locked cell
  localparam color_t C_YELLOW = 3'b110;  // Falling piece
  localparam color_t C_WHITE  = 3'b111;  // Border ring
  localparam color_t C_GREEN  = 3'b010;  // Score bar
  localparam color_t C_RED    = 3'b100;  // Locked cell once the game is over

endpackage

//--- game_pkg.sv
`include "stacker_cfg.svh"

package game_pkg;

  // Row 0 is the top of the playfield
  typedef logic [4:0] row_t;

  typedef logic [3:0] col_t;

  // One bit per cell, set once a piece has locked there
  typedef logic [`BOARD_ROWS-1:0][`BOARD_COLS-1:0] board_t;

  // Cleared row count
  typedef logic [7:0] score_t;

  localparam score_t SCORE_MAX = 8'd255;  // Saturation point

endpackage

//--- stacker_cfg.svh
`ifndef STACKER_CFG_SVH
`define STACKER_CFG_SVH

// Playfield in cells
`define BOARD_ROWS 20
`define BOARD_COLS 10
`define SPAWN_COL  4

// Cell side and board origin in pixels
`define CELL_PX  8
`define BOARD_X0 280
`define BOARD_Y0 80

// 640x480 scan timing, horizontal in pixels
`define H_ACTIVE 640
`define H_FP     16
`define H_SYNC   96
`define H_BP     48

// Vertical in lines
`define V_ACTIVE 480
`define V_FP     10
`define V_SYNC   2
`define V_BP     33

`define TICK_BASE 4096  // Slowest drop interval in cycles

`endif
